// File: src/arm_macros.svh
`ifndef ARM_MACROS_SVH
`define ARM_MACROS_SVH

// Data and address width
`define ARM_XLEN 32

// Register index width
`define ARM_RIDX 4

`define ARM_PC_STEP 4

`endif

// File: src/armPkg.sv
`default_nettype none

package armPkg;

  // ALU operations, RSB is AluSub with swapped operands
  typedef enum logic [3:0] {
    AluAdd = 4'd0,
    AluSub = 4'd1,
    AluAnd = 4'd2,
    AluOrr = 4'd3,
    AluAdc = 4'd4,
    AluCmp = 4'd5,
    AluTst = 4'd6
  } aluOpT;

  // Immediate formats
  typedef enum logic [1:0] {
    ImmDp  = 2'd0,
    ImmMem = 2'd1,
    ImmBr  = 2'd2
  } immSrcT;

  // Execute operand source
  typedef enum logic [1:0] {
    FwdReg = 2'd0,
    FwdWb  = 2'd1,
    FwdMem = 2'd2
  } fwdSelT;

  // Matches the cond field encoding
  typedef enum logic [3:0] {
    CondEq = 4'b0000,
    CondNe = 4'b0001,
    CondAl = 4'b1110
  } condT;

endpackage

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "arm_macros.svh"

module regFile (
  input  logic                 clk,
  input  logic                 we3,
  input  logic [`ARM_RIDX-1:0] ra1,
  input  logic [`ARM_RIDX-1:0] ra2,
  input  logic [`ARM_RIDX-1:0] wa3,
  input  logic [`ARM_XLEN-1:0] wd3,
  input  logic [`ARM_XLEN-1:0] r15,
  output logic [`ARM_XLEN-1:0] rd1,
  output logic [`ARM_XLEN-1:0] rd2
);

  logic [`ARM_XLEN-1:0] rf [0:14];

  // Falling edge write lets decode read the value in the same cycle
  always_ff @(negedge clk) begin
    if (we3 && (wa3 != {`ARM_RIDX{1'b1}})) begin
      rf[wa3] <= wd3;
    end
  end

  // R15 is the PC plus 8
  assign rd1 = (ra1 == {`ARM_RIDX{1'b1}}) ? r15 : rf[ra1];
  assign rd2 = (ra2 == {`ARM_RIDX{1'b1}}) ? r15 : rf[ra2];

endmodule

`default_nettype wire

// File: src/immExtend.sv
`timescale 1ns/1ps
`default_nettype none
`include "arm_macros.svh"

module immExtend (
  input  logic [23:0]           instr,
  input  armPkg::immSrcT        immSrc,
  output logic [`ARM_XLEN-1:0]  extImm
);

  logic [`ARM_XLEN-1:0]   imm8;
  logic [2*`ARM_XLEN-1:0] rotWide;
  logic [4:0]             rotAmt;

  assign imm8   = {{(`ARM_XLEN-8){1'b0}}, instr[7:0]};
  // Rotate right by twice the rotate field
  assign rotAmt = {instr[11:8], 1'b0};

  always_comb begin
    rotWide = {imm8, imm8} >> rotAmt;
    case (immSrc)
      armPkg::ImmDp: begin
        extImm = rotWide[`ARM_XLEN-1:0];
      end
      armPkg::ImmMem: begin
        extImm = {{(`ARM_XLEN-12){1'b0}}, instr[11:0]};
      end
      // Word offset, sign extended
      armPkg::ImmBr: begin
        extImm = {{(`ARM_XLEN-26){instr[23]}}, instr[23:0], 2'b00};
      end
      default: begin
        extImm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "arm_macros.svh"

module alu (
  input  logic [`ARM_XLEN-1:0] a,
  input  logic [`ARM_XLEN-1:0] b,
  input  armPkg::aluOpT        aluControl,
  input  logic                 carryIn,
  output logic [`ARM_XLEN-1:0] result,
  output logic [3:0]           flags,
  output logic                 noWrite
);

  logic [`ARM_XLEN-1:0] bOp;
  logic                 cIn;
  logic [`ARM_XLEN:0]   sum;
  logic                 additive;
  logic                 carry;
  logic                 overflow;

  always_comb begin
    bOp      = b;
    cIn      = 1'b0;
    additive = 1'b1;
    case (aluControl)
      armPkg::AluSub, armPkg::AluCmp: begin
        bOp = ~b;
        cIn = 1'b1;
      end
      armPkg::AluAdc: begin
        cIn = carryIn;
      end
      armPkg::AluAnd, armPkg::AluOrr, armPkg::AluTst: begin
        additive = 1'b0;
      end
      default: begin
        cIn = 1'b0;
      end
    endcase
  end

  // Carry out of a + ~b + 1 is the ARM not-borrow
  assign sum = {1'b0, a} + {1'b0, bOp} + {{`ARM_XLEN{1'b0}}, cIn};

  always_comb begin
    case (aluControl)
      armPkg::AluAnd, armPkg::AluTst: result = a & b;
      armPkg::AluOrr:                 result = a | b;
      default:                        result = sum[`ARM_XLEN-1:0];
    endcase
  end

  assign overflow = additive & (a[`ARM_XLEN-1] == bOp[`ARM_XLEN-1]) &
                    (sum[`ARM_XLEN-1] != a[`ARM_XLEN-1]);
  // Logic ops leave carry as it was
  assign carry    = additive ? sum[`ARM_XLEN] : carryIn;

  assign flags   = {result[`ARM_XLEN-1], (result == '0), carry, overflow};
  assign noWrite = (aluControl == armPkg::AluCmp) || (aluControl == armPkg::AluTst);

endmodule

`default_nettype wire

// File: src/datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "arm_macros.svh"

module datapath (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [1:0]           regSrcD,
  input  armPkg::immSrcT       immSrcD,
  input  logic                 aluSrcE,
  input  armPkg::aluOpT        aluControlE,
  input  logic                 branchTakenE,
  input  logic                 swapE,
  input  logic                 carryInE,
  input  logic                 memToRegW,
  input  logic                 pcSrcW,
  input  logic                 regWriteW,
  output logic [`ARM_XLEN-1:0] pcF,
  input  logic [`ARM_XLEN-1:0] instrF,
  output logic [`ARM_XLEN-1:0] instrD,
  output logic [`ARM_XLEN-1:0] aluOutM,
  output logic [`ARM_XLEN-1:0] writeDataM,
  input  logic [`ARM_XLEN-1:0] readDataM,
  output logic [3:0]           aluFlagsE,
  output logic                 noWriteE,
  output logic                 match1EM,
  output logic                 match1EW,
  output logic                 match2EM,
  output logic                 match2EW,
  output logic                 match12DE,
  input  armPkg::fwdSelT       forwardAE,
  input  armPkg::fwdSelT       forwardBE,
  input  logic                 stallF,
  input  logic                 stallD,
  input  logic                 flushD,
  input  logic                 flushE
);

  logic [`ARM_XLEN-1:0] pcPlus4F, pcNextF;
  logic [`ARM_XLEN-1:0] extImmD, rd1D, rd2D;
  logic [`ARM_XLEN-1:0] rd1E, rd2E, extImmE, srcAE, writeDataE, srcBE;
  logic [`ARM_XLEN-1:0] aluAE, aluBE, aluResultE;
  logic [`ARM_XLEN-1:0] aluOutW, readDataW, resultW;
  logic [`ARM_RIDX-1:0] ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;

  // Fetch
  assign pcPlus4F = pcF + `ARM_PC_STEP;
  assign pcNextF  = branchTakenE ? aluResultE : (pcSrcW ? resultW : pcPlus4F);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= '0;
    end else if (flushD) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  // Decode
  assign ra1D = regSrcD[0] ? {`ARM_RIDX{1'b1}} : instrD[19:16];
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];

  // PC+4 of fetch is PC+8 of the decode instruction
  regFile u_regFile (
    .clk  (clk),
    .we3  (regWriteW),
    .ra1  (ra1D),
    .ra2  (ra2D),
    .wa3  (wa3W),
    .wd3  (resultW),
    .r15  (pcPlus4F),
    .rd1  (rd1D),
    .rd2  (rd2D)
  );

  immExtend u_immExtend (
    .instr  (instrD[23:0]),
    .immSrc (immSrcD),
    .extImm (extImmD)
  );

  // Execute
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else if (flushE) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      wa3E <= instrD[15:12];
    end
  end

  always_comb begin
    case (forwardAE)
      armPkg::FwdWb:  srcAE = resultW;
      armPkg::FwdMem: srcAE = aluOutM;
      default:        srcAE = rd1E;
    endcase
    case (forwardBE)
      armPkg::FwdWb:  writeDataE = resultW;
      armPkg::FwdMem: writeDataE = aluOutM;
      default:        writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? extImmE : writeDataE;
  // Swap for RSB
  assign aluAE = swapE ? srcBE : srcAE;
  assign aluBE = swapE ? srcAE : srcBE;

  alu u_alu (
    .a          (aluAE),
    .b          (aluBE),
    .aluControl (aluControlE),
    .carryIn    (carryInE),
    .result     (aluResultE),
    .flags      (aluFlagsE),
    .noWrite    (noWriteE)
  );

  // Memory
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
  end

  // Writeback
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wa3M <= '0;
      wa3W <= '0;
    end else begin
      wa3M <= wa3E;
      wa3W <= wa3M;
    end
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

  // Register match flags for the hazard unit
  assign match1EM  = (wa3M == ra1E);
  assign match1EW  = (wa3W == ra1E);
  assign match2EM  = (wa3M == ra2E);
  assign match2EW  = (wa3W == ra2E);
  assign match12DE = (wa3E == ra1D) | (wa3E == ra2D);

endmodule

`default_nettype wire

// File: src/controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "arm_macros.svh"

module controller (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [`ARM_XLEN-1:0] instrD,
  input  logic [3:0]           aluFlagsE,
  input  logic                 noWriteE,
  input  logic                 flushE,
  output logic [1:0]           regSrcD,
  output armPkg::immSrcT       immSrcD,
  output logic                 aluSrcE,
  output armPkg::aluOpT        aluControlE,
  output logic                 swapE,
  output logic                 carryInE,
  output logic                 branchTakenE,
  output logic                 memToRegE,
  output logic                 regWriteM,
  output logic                 memWriteM,
  output logic                 regWriteW,
  output logic                 memToRegW,
  output logic                 pcSrcW
);

  logic          regWriteD, memWriteD, memToRegD, branchD, aluSrcD;
  logic          flagWriteD, swapD, pcSrcD;
  armPkg::aluOpT aluControlD;
  logic          regWriteE, memWriteE, branchE, flagWriteE, pcSrcE;
  armPkg::condT  condE;
  logic          condPassE, keepE;
  logic          memToRegM, pcSrcM;
  logic [3:0]    nzcv;

  // Decode of op, funct and cmd
  always_comb begin
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memToRegD   = 1'b0;
    branchD     = 1'b0;
    aluSrcD     = 1'b0;
    flagWriteD  = 1'b0;
    swapD       = 1'b0;
    regSrcD     = 2'b00;
    immSrcD     = armPkg::ImmDp;
    aluControlD = armPkg::AluAdd;
    case (instrD[27:26])
      2'b00: begin
        regWriteD  = 1'b1;
        aluSrcD    = instrD[25];
        flagWriteD = instrD[20];
        case (instrD[24:21])
          4'b0100: aluControlD = armPkg::AluAdd;
          4'b0010: aluControlD = armPkg::AluSub;
          4'b0011: begin
            aluControlD = armPkg::AluSub;
            swapD       = 1'b1;
          end
          4'b0000: aluControlD = armPkg::AluAnd;
          4'b1100: aluControlD = armPkg::AluOrr;
          4'b0101: aluControlD = armPkg::AluAdc;
          4'b1010: aluControlD = armPkg::AluCmp;
          4'b1000: aluControlD = armPkg::AluTst;
          default: begin
            regWriteD  = 1'b0;
            flagWriteD = 1'b0;
          end
        endcase
      end
      2'b01: begin
        aluSrcD     = 1'b1;
        immSrcD     = armPkg::ImmMem;
        // U bit picks offset direction
        aluControlD = instrD[23] ? armPkg::AluAdd : armPkg::AluSub;
        if (instrD[20]) begin
          regWriteD = 1'b1;
          memToRegD = 1'b1;
        end else begin
          memWriteD = 1'b1;
          regSrcD   = 2'b10;
        end
      end
      2'b10: begin
        branchD = 1'b1;
        aluSrcD = 1'b1;
        regSrcD = 2'b01;
        immSrcD = armPkg::ImmBr;
      end
      default: begin
        regSrcD = 2'b00;
      end
    endcase
  end

  // Write to R15 redirects the PC at writeback
  assign pcSrcD = regWriteD & (instrD[15:12] == 4'hF);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memToRegE   <= 1'b0;
      branchE     <= 1'b0;
      aluSrcE     <= 1'b0;
      flagWriteE  <= 1'b0;
      swapE       <= 1'b0;
      pcSrcE      <= 1'b0;
      aluControlE <= armPkg::AluAdd;
      condE       <= armPkg::CondEq;
    end else if (flushE) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memToRegE   <= 1'b0;
      branchE     <= 1'b0;
      aluSrcE     <= 1'b0;
      flagWriteE  <= 1'b0;
      swapE       <= 1'b0;
      pcSrcE      <= 1'b0;
      aluControlE <= armPkg::AluAdd;
      condE       <= armPkg::CondEq;
    end else begin
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      memToRegE   <= memToRegD;
      branchE     <= branchD;
      aluSrcE     <= aluSrcD;
      flagWriteE  <= flagWriteD;
      swapE       <= swapD;
      pcSrcE      <= pcSrcD;
      aluControlE <= aluControlD;
      condE       <= armPkg::condT'(instrD[31:28]);
    end
  end

  always_comb begin
    case (condE)
      armPkg::CondEq: condPassE = nzcv[2];
      armPkg::CondNe: condPassE = ~nzcv[2];
      armPkg::CondAl: condPassE = 1'b1;
      default:        condPassE = 1'b0;
    endcase
  end

  assign keepE        = condPassE & ~noWriteE;
  assign branchTakenE = branchE & keepE;
  assign carryInE     = nzcv[1];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      nzcv <= 4'b0000;
    end else if (flagWriteE && condPassE) begin
      nzcv <= aluFlagsE;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else begin
      regWriteM <= regWriteE & keepE;
      memWriteM <= memWriteE & keepE;
      memToRegM <= memToRegE;
      pcSrcM    <= pcSrcE & keepE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
      pcSrcW    <= pcSrcM;
    end
  end

endmodule

`default_nettype wire

// File: src/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input  logic           match1EM,
  input  logic           match1EW,
  input  logic           match2EM,
  input  logic           match2EW,
  input  logic           match12DE,
  input  logic           regWriteM,
  input  logic           regWriteW,
  input  logic           memToRegE,
  input  logic           branchTakenE,
  output armPkg::fwdSelT forwardAE,
  output armPkg::fwdSelT forwardBE,
  output logic           stallF,
  output logic           stallD,
  output logic           flushD,
  output logic           flushE
);

  logic ldrStall;

  // Memory stage has the newer value
  assign forwardAE = (match1EM && regWriteM) ? armPkg::FwdMem :
                     (match1EW && regWriteW) ? armPkg::FwdWb  : armPkg::FwdReg;
  assign forwardBE = (match2EM && regWriteM) ? armPkg::FwdMem :
                     (match2EW && regWriteW) ? armPkg::FwdWb  : armPkg::FwdReg;

  // Load in execute feeding decode
  assign ldrStall = match12DE & memToRegE;

  assign stallF = ldrStall;
  assign stallD = ldrStall;
  assign flushD = branchTakenE;
  assign flushE = ldrStall | branchTakenE;

endmodule

`default_nettype wire

// File: src/armPipeline.sv
`timescale 1ns/1ps
`default_nettype none
`include "arm_macros.svh"

module armPipeline (
  input  logic                 clk,
  input  logic                 rstN,
  output logic [`ARM_XLEN-1:0] pcF,
  input  logic [`ARM_XLEN-1:0] instrF,
  output logic [`ARM_XLEN-1:0] aluOutM,
  output logic [`ARM_XLEN-1:0] writeDataM,
  output logic                 memWriteM,
  input  logic [`ARM_XLEN-1:0] readDataM
);

  logic [1:0]           regSrcD;
  armPkg::immSrcT       immSrcD;
  armPkg::aluOpT        aluControlE;
  armPkg::fwdSelT       forwardAE, forwardBE;
  logic [`ARM_XLEN-1:0] instrD;
  logic [3:0]           aluFlagsE;
  logic                 aluSrcE, swapE, carryInE, branchTakenE, memToRegE, noWriteE;
  logic                 regWriteM, regWriteW, memToRegW, pcSrcW;
  logic                 match1EM, match1EW, match2EM, match2EW, match12DE;
  logic                 stallF, stallD, flushD, flushE;

  controller u_controller (
    .clk (clk), .rstN (rstN), .instrD (instrD), .aluFlagsE (aluFlagsE),
    .noWriteE (noWriteE), .flushE (flushE), .regSrcD (regSrcD), .immSrcD (immSrcD),
    .aluSrcE (aluSrcE), .aluControlE (aluControlE), .swapE (swapE),
    .carryInE (carryInE), .branchTakenE (branchTakenE), .memToRegE (memToRegE),
    .regWriteM (regWriteM), .memWriteM (memWriteM), .regWriteW (regWriteW),
    .memToRegW (memToRegW), .pcSrcW (pcSrcW)
  );

  datapath u_datapath (
    .clk (clk), .rstN (rstN), .regSrcD (regSrcD), .immSrcD (immSrcD),
    .aluSrcE (aluSrcE), .aluControlE (aluControlE), .branchTakenE (branchTakenE),
    .swapE (swapE), .carryInE (carryInE), .memToRegW (memToRegW), .pcSrcW (pcSrcW),
    .regWriteW (regWriteW), .pcF (pcF), .instrF (instrF), .instrD (instrD),
    .aluOutM (aluOutM), .writeDataM (writeDataM), .readDataM (readDataM),
    .aluFlagsE (aluFlagsE), .noWriteE (noWriteE), .match1EM (match1EM),
    .match1EW (match1EW), .match2EM (match2EM), .match2EW (match2EW),
    .match12DE (match12DE), .forwardAE (forwardAE), .forwardBE (forwardBE),
    .stallF (stallF), .stallD (stallD), .flushD (flushD), .flushE (flushE)
  );

  hazardUnit u_hazardUnit (
    .match1EM (match1EM), .match1EW (match1EW), .match2EM (match2EM),
    .match2EW (match2EW), .match12DE (match12DE), .regWriteM (regWriteM),
    .regWriteW (regWriteW), .memToRegE (memToRegE), .branchTakenE (branchTakenE),
    .forwardAE (forwardAE), .forwardBE (forwardBE), .stallF (stallF),
    .stallD (stallD), .flushD (flushD), .flushE (flushE)
  );

endmodule

`default_nettype wire

// File: tests/tbArmPipeline.sv
`timescale 1ns/1ps
`default_nettype none
`include "arm_macros.svh"

module tbArmPipeline;

  localparam int clkPeriod      = 40;
  localparam int memWords       = 256;
  localparam int progWords      = 39;
  // Program length plus slack for stalls, flushes and drain
  localparam int watchdogCycles = 5 * progWords + 5;

  // Data-processing cmd field
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdRsb = 4'b0011;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdAdc = 4'b0101;
  localparam logic [3:0] cmdTst = 4'b1000;
  localparam logic [3:0] cmdCmp = 4'b1010;
  localparam logic [3:0] cmdOrr = 4'b1100;

  logic                 clk;
  logic                 rstN;
  logic [`ARM_XLEN-1:0] pcF;
  logic [`ARM_XLEN-1:0] instrF;
  logic [`ARM_XLEN-1:0] aluOutM;
  logic [`ARM_XLEN-1:0] writeDataM;
  logic [`ARM_XLEN-1:0] readDataM;
  logic                 memWriteM;

  logic [`ARM_XLEN-1:0] imem [0:memWords-1];
  logic [`ARM_XLEN-1:0] dmem [0:memWords-1];
  logic [`ARM_XLEN-1:0] expAddr [$];
  logic [`ARM_XLEN-1:0] expData [$];
  logic [`ARM_XLEN-1:0] logAddr [$];
  logic [`ARM_XLEN-1:0] logData [$];
  int                   expCount;
  int                   storeCount;
  int                   errors;
  integer               seed;

  armPipeline u_armPipeline (
    .clk        (clk),
    .rstN       (rstN),
    .pcF        (pcF),
    .instrF     (instrF),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM),
    .memWriteM  (memWriteM),
    .readDataM  (readDataM)
  );

  function automatic logic [31:0] immOp(input logic [3:0] cmd, input logic s,
                                        input logic [3:0] rn, input logic [3:0] rd,
                                        input logic [3:0] rot, input logic [7:0] imm8);
    return {armPkg::CondAl, 3'b001, cmd, s, rn, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] regOp(input logic [3:0] cmd, input logic s,
                                        input logic [3:0] rn, input logic [3:0] rd,
                                        input logic [3:0] rm);
    return {armPkg::CondAl, 3'b000, cmd, s, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed, offset added, no writeback
  function automatic logic [31:0] memOp(input logic load, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [11:0] off);
    return {armPkg::CondAl, 3'b010, 4'b1100, load, rn, rd, off};
  endfunction

  function automatic logic [31:0] branchOp(input armPkg::condT cond, input logic [23:0] off);
    return {cond, 4'b1010, off};
  endfunction

  task automatic fillMemories();
    int i;
    for (i = 0; i < memWords; i++) begin
      imem[i] = '0;
      dmem[i] = i * 32'h9E37_79B1;
    end
    // Words read by the two loads
    dmem[16] = $random(seed);
    dmem[17] = $random(seed);
  endtask

  task automatic loadProgram();
    imem[0]  = regOp(cmdSub, 1'b0, 4'd15, 4'd0, 4'd15);
    imem[1]  = immOp(cmdAdd, 1'b0, 4'd0, 4'd1, 4'd0, 8'h80);
    // Dependent chain, operands forwarded from M and W
    imem[2]  = immOp(cmdAdd, 1'b0, 4'd0, 4'd2, 4'd0, 8'h35);
    imem[3]  = immOp(cmdAdd, 1'b0, 4'd2, 4'd3, 4'd0, 8'h5A);
    imem[4]  = regOp(cmdSub, 1'b0, 4'd3, 4'd4, 4'd2);
    imem[5]  = regOp(cmdAnd, 1'b0, 4'd4, 4'd5, 4'd3);
    imem[6]  = regOp(cmdOrr, 1'b0, 4'd5, 4'd6, 4'd2);
    imem[7]  = memOp(1'b0, 4'd6, 4'd1, 12'd0);
    imem[8]  = memOp(1'b0, 4'd5, 4'd1, 12'd4);
    imem[9]  = memOp(1'b0, 4'd4, 4'd1, 12'd8);
    imem[10] = memOp(1'b0, 4'd3, 4'd1, 12'd12);
    // Rotated immediates and RSB
    imem[11] = immOp(cmdAdd, 1'b0, 4'd0, 4'd7, 4'd4, 8'hFF);
    imem[12] = immOp(cmdRsb, 1'b0, 4'd2, 4'd8, 4'd0, 8'hC8);
    imem[13] = immOp(cmdAdd, 1'b0, 4'd0, 4'd9, 4'd1, 8'hAB);
    imem[14] = memOp(1'b0, 4'd7, 4'd1, 12'd16);
    imem[15] = memOp(1'b0, 4'd8, 4'd1, 12'd20);
    imem[16] = memOp(1'b0, 4'd9, 4'd1, 12'd24);
    // Load-use pairs
    imem[17] = memOp(1'b1, 4'd10, 4'd0, 12'h040);
    imem[18] = regOp(cmdAdd, 1'b0, 4'd10, 4'd11, 4'd2);
    imem[19] = memOp(1'b1, 4'd12, 4'd0, 12'h044);
    imem[20] = regOp(cmdSub, 1'b0, 4'd12, 4'd13, 4'd10);
    imem[21] = memOp(1'b0, 4'd11, 4'd1, 12'd28);
    imem[22] = memOp(1'b0, 4'd13, 4'd1, 12'd32);
    // CMP and TST carry a live Rd that must stay untouched
    imem[23] = regOp(cmdCmp, 1'b1, 4'd3, 4'd7, 4'd2);
    imem[24] = regOp(cmdAdc, 1'b0, 4'd2, 4'd14, 4'd3);
    imem[25] = memOp(1'b0, 4'd7, 4'd1, 12'd36);
    imem[26] = memOp(1'b0, 4'd14, 4'd1, 12'd40);
    imem[27] = regOp(cmdTst, 1'b1, 4'd7, 4'd6, 4'd0);
    imem[28] = immOp(cmdAdc, 1'b0, 4'd2, 4'd12, 4'd0, 8'h10);
    imem[29] = memOp(1'b0, 4'd6, 4'd1, 12'd44);
    imem[30] = memOp(1'b0, 4'd12, 4'd1, 12'd48);
    // BEQ to word 34, Z is set by the TST
    imem[31] = branchOp(armPkg::CondEq, 24'd1);
    imem[32] = memOp(1'b0, 4'd2, 4'd1, 12'd52);
    imem[33] = memOp(1'b0, 4'd3, 4'd1, 12'd56);
    imem[34] = memOp(1'b0, 4'd4, 4'd1, 12'd60);
    imem[35] = branchOp(armPkg::CondNe, 24'd1);
    imem[36] = memOp(1'b0, 4'd5, 4'd1, 12'd64);
    imem[37] = memOp(1'b0, 4'd8, 4'd1, 12'd68);
    // Park on a branch to self
    imem[38] = branchOp(armPkg::CondAl, 24'hFF_FFFE);
  endtask

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic buildExpected();
    logic [31:0] r2, r3, r4, r5, r6, r8, r11, r12, r13, r14;
    logic [31:0] ld0, ld1;
    logic        carry;
    ld0   = dmem[16];
    ld1   = dmem[17];
    r2    = 32'h35;
    r3    = r2 + 32'h5A;
    r4    = r3 - r2;
    r5    = r4 & r3;
    r6    = r5 | r2;
    r8    = 32'd200 - r2;
    r11   = ld0 + r2;
    r13   = ld1 - ld0;
    // No borrow on CMP r3, r2 means C set
    carry = (r3 >= r2);
    r14   = r2 + r3 + carry;
    // TST keeps C
    r12   = r2 + 32'h10 + carry;
    expectStore(32'h80, r6);
    expectStore(32'h84, r5);
    expectStore(32'h88, r4);
    expectStore(32'h8C, r3);
    expectStore(32'h90, 32'hFF00_0000);
    expectStore(32'h94, r8);
    expectStore(32'h98, 32'hC000_002A);
    expectStore(32'h9C, r11);
    expectStore(32'hA0, r13);
    expectStore(32'hA4, 32'hFF00_0000);
    expectStore(32'hA8, r14);
    expectStore(32'hAC, r6);
    expectStore(32'hB0, r12);
    // 0xB4 and 0xB8 are skipped by the taken BEQ
    expectStore(32'hBC, r4);
    expectStore(32'hC0, r5);
    expectStore(32'hC4, r8);
    expCount = expAddr.size();
  endtask

  task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
    int idx;
    idx = logAddr.size();
    logAddr.push_back(addr);
    logData.push_back(data);
    if (idx >= expCount) begin
      $display("Unexpected extra store %0d at %0t ns to address %h", idx, $time, addr);
      errors++;
    end else begin
      addrMatch: assert (addr === expAddr[idx]) else begin
        $display("CHECK FAILED at %0t ns: store %0d address %h, expected %h",
                 $time, idx, addr, expAddr[idx]);
        errors++;
      end
      dataMatch: assert (data === expData[idx]) else begin
        $display("CHECK FAILED at %0t ns: store %0d to %h data %h, expected %h",
                 $time, idx, addr, data, expData[idx]);
        errors++;
      end
    end
    storeCount = idx + 1;
  endtask

  task automatic printSummary();
    $display("errors: %0d, stores seen: %0d of %0d", errors, storeCount, expCount);
  endtask

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Memories answer 2 ns after the edge, as if read combinationally
  always @(posedge clk) begin
    #2;
    instrF    <= imem[pcF[9:2]];
    readDataM <= dmem[aluOutM[9:2]];
  end

  // Mid-cycle sampling of the store port
  always @(negedge clk) begin
    if (!rstN) begin
      resetQuiet: assert (memWriteM === 1'b0 && pcF === '0) else begin
        $display("CHECK FAILED at %0t ns: in reset memWriteM=%b pcF=%h",
                 $time, memWriteM, pcF);
        errors++;
      end
    end else if (memWriteM === 1'b1) begin
      dmem[aluOutM[9:2]] = writeDataM;
      checkStore(aluOutM, writeDataM);
    end else if (memWriteM !== 1'b0) begin
      $display("memWriteM is unknown at %0t ns", $time);
      errors++;
    end
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Timeout after %0d cycles, only %0d of %0d stores seen",
             watchdogCycles, storeCount, expCount);
    printSummary();
    $display("sim failed");
    $finish;
  end

  initial begin
    seed       = 32'h8703_a7e0;
    rstN       = 1'b0;
    instrF     = '0;
    readDataM  = '0;
    errors     = 0;
    storeCount = 0;
    expCount   = 0;
    fillMemories();
    loadProgram();
    buildExpected();
    repeat (2) @(posedge clk);
    #2;
    rstN = 1'b1;
    wait (storeCount >= expCount);
    // Drain so a late extra store is caught
    repeat (8) @(posedge clk);
    countMatch: assert (storeCount == expCount) else begin
      $display("Wrong number of stores: %0d seen, %0d expected", storeCount, expCount);
      errors++;
    end
    printSummary();
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/armPkg.sv
src/regFile.sv
src/immExtend.sv
src/alu.sv
src/datapath.sv
src/controller.sv
src/hazardUnit.sv
src/armPipeline.sv
tests/tbArmPipeline.sv

// File: Bender.yml
package:
  name: arm_pipeline

sources:
  - include_dirs:
      - src
    files:
      - src/armPkg.sv
      - src/regFile.sv
      - src/immExtend.sv
      - src/alu.sv
      - src/datapath.sv
      - src/controller.sv
      - src/hazardUnit.sv
      - src/armPipeline.sv
      - target: test
        files:
          - tests/tbArmPipeline.sv
